// File: common/ram_pkg.sv
// Sizes, derived widths and the write arbiter priority type for the register-file RAM
package ram_pkg;

  // Storage geometry
  localparam int ram_depth = 16;
  localparam int ram_width = 32;

  // Granularity of one byte enable
  localparam int ram_word_width = 8;

  // Address needs at least one bit even for a single entry
  localparam int ram_addr_width = (ram_depth > 1) ? $clog2(ram_depth) : 1;

  localparam int ram_num_words = ram_width / ram_word_width;

  // Two peer clients share the single write port
  localparam int num_writers = 2;

  // Which client wins the next conflicting cycle
  typedef enum logic {
    pri_client0 = 1'b0,
    pri_client1 = 1'b1
  } arb_pri_e;

endpackage

// File: common/ram_wr_if.sv
// Write bus carrying one granted write from the arbiter into the storage array
`timescale 1ns/1ns

interface ram_wr_if import ram_pkg::*; ();

  // One-cycle strobe, always taken by the storage in that cycle
  logic                      valid;
  logic [ram_addr_width-1:0] addr;
  logic [ram_width-1:0]      data;
  // One bit per byte word
  logic [ram_num_words-1:0]  word_en;

  modport arbiter (
    output valid,
    output addr,
    output data,
    output word_en
  );

  modport storage (
    input valid,
    input addr,
    input data,
    input word_en
  );

endinterface

// File: logic/wr_arbiter.sv
// Two-client round-robin write arbiter with same-cycle grant and write steering
`timescale 1ns/1ns

module wr_arbiter import ram_pkg::*; (
  input  logic                                          wr_clk,
  input  logic                                          wr_rst,
  input  logic [num_writers-1:0]                        req_valid,
  input  logic [num_writers-1:0][ram_addr_width-1:0]    req_addr,
  input  logic [num_writers-1:0][ram_width-1:0]         req_data,
  input  logic [num_writers-1:0][ram_num_words-1:0]     req_word_en,
  output logic [num_writers-1:0]                        grant,
  ram_wr_if.arbiter                                     wr
);

  arb_pri_e pri_q;
  logic     both_req;
  logic     win_idx;

  assign both_req = &req_valid;

  // Grant is combinational in the request cycle
  always_comb begin
    grant = '0;
    if (both_req) begin
      // Conflict goes to whichever client holds priority
      grant[pri_q == pri_client1] = 1'b1;
    end else begin
      // A lone requester always wins
      grant = req_valid;
    end
  end

  // Priority only moves on a conflict so the loser wins next cycle
  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      pri_q <= pri_client0;
    end else if (both_req) begin
      pri_q <= (pri_q == pri_client0) ? pri_client1 : pri_client0;
    end
  end

  assign win_idx = grant[1];

  // Steer the winner onto the write bus
  assign wr.valid   = |grant;
  assign wr.addr    = req_addr[win_idx];
  assign wr.data    = req_data[win_idx];
  assign wr.word_en = req_word_en[win_idx];

endmodule

// File: ram/ram_flops.sv
// Flop storage array with byte enables, one write stage with read bypass and registered read
`timescale 1ns/1ns

module ram_flops import ram_pkg::*; #(
  parameter int depth        = ram_depth,
  parameter int width        = ram_width,
  parameter int word_width   = ram_word_width,
  parameter bit enable_reset = 1'b1,
  localparam int addr_width  = (depth > 1) ? $clog2(depth) : 1,
  localparam int num_words   = width / word_width
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst,
  ram_wr_if.storage             wr,
  input  logic                  rd_addr_valid,
  input  logic [addr_width-1:0] rd_addr,
  output logic                  rd_data_valid,
  output logic [width-1:0]      rd_data
);

  // Write stage holding the write granted in the previous cycle
  logic                  stg_valid;
  logic [addr_width-1:0] stg_addr;
  logic [width-1:0]      stg_data;
  logic [num_words-1:0]  stg_word_en;

  logic [width-1:0]      mem [depth];
  logic [width-1:0]      commit_data;
  logic [width-1:0]      rd_merge;
  logic                  rd_hit;

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= wr.valid;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr.valid) begin
      stg_addr    <= wr.addr;
      stg_data    <= wr.data;
      stg_word_en <= wr.word_en;
    end
  end

  // Merge the staged bytes over the current entry contents
  always_comb begin
    commit_data = mem[stg_addr];
    for (int w = 0; w < num_words; w++) begin
      if (stg_word_en[w]) begin
        commit_data[w*word_width +: word_width] = stg_data[w*word_width +: word_width];
      end
    end
  end

  if (enable_reset) begin : gen_mem_rst
    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        for (int i = 0; i < depth; i++) begin
          mem[i] <= '0;
        end
      end else if (stg_valid) begin
        mem[stg_addr] <= commit_data;
      end
    end
  end else begin : gen_mem_norst
    always_ff @(posedge wr_clk) begin
      if (stg_valid) begin
        mem[stg_addr] <= commit_data;
      end
    end
  end

  // Bypass the staged write when it targets the read address
  assign rd_hit = stg_valid && (stg_addr == rd_addr);

  always_comb begin
    rd_merge = mem[rd_addr];
    for (int w = 0; w < num_words; w++) begin
      if (rd_hit && stg_word_en[w]) begin
        rd_merge[w*word_width +: word_width] = stg_data[w*word_width +: word_width];
      end
    end
  end

  // Read data returns exactly one cycle after the address
  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      rd_data_valid <= 1'b0;
      rd_data       <= '0;
    end else begin
      rd_data_valid <= rd_addr_valid;
      if (rd_addr_valid) begin
        rd_data <= rd_merge;
      end
    end
  end

endmodule

// File: ram/ram_subsys.sv
// Top level joining the write arbiter and the flop storage over the write bus
`timescale 1ns/1ns

module ram_subsys import ram_pkg::*; #(
  parameter int depth        = ram_depth,
  parameter int width        = ram_width,
  parameter int word_width   = ram_word_width,
  parameter bit enable_reset = 1'b1,
  localparam int addr_width  = (depth > 1) ? $clog2(depth) : 1,
  localparam int num_words   = width / word_width
) (
  input  logic                                    wr_clk,
  input  logic                                    wr_rst,

  // Write clients, one slice per client
  input  logic [num_writers-1:0]                  wr_valid,
  input  logic [num_writers-1:0][addr_width-1:0]  wr_addr,
  input  logic [num_writers-1:0][width-1:0]       wr_data,
  input  logic [num_writers-1:0][num_words-1:0]   wr_word_en,
  output logic [num_writers-1:0]                  wr_grant,

  // Single read port
  input  logic                                    rd_addr_valid,
  input  logic [addr_width-1:0]                   rd_addr,
  output logic                                    rd_data_valid,
  output logic [width-1:0]                        rd_data
);

  // Granted write travelling to the storage
  ram_wr_if wr_bus ();

  wr_arbiter wr_arbiter_i0 (
    .wr_clk      (wr_clk),
    .wr_rst      (wr_rst),
    .req_valid   (wr_valid),
    .req_addr    (wr_addr),
    .req_data    (wr_data),
    .req_word_en (wr_word_en),
    .grant       (wr_grant),
    .wr          (wr_bus)
  );

  ram_flops #(
    .depth        (depth),
    .width        (width),
    .word_width   (word_width),
    .enable_reset (enable_reset)
  ) ram_flops_i0 (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr            (wr_bus),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

endmodule

// File: dv/ram_subsys_properties.sv
// Concurrent checks on write grants and read timing of the RAM subsystem, with their bind
`timescale 1ns/1ns

module ram_subsys_properties import ram_pkg::*; (
  input logic                   wr_clk,
  input logic                   wr_rst,
  input logic [num_writers-1:0] wr_valid,
  input logic [num_writers-1:0] wr_grant,
  input logic                   rd_addr_valid,
  input logic                   rd_data_valid
);

  // Number of assertion failures so far
  int fail_count = 0;

  grant_onehot: assert property (
    @(posedge wr_clk) disable iff (wr_rst) !(wr_grant[0] && wr_grant[1])
  ) else begin
    fail_count++;
    $error("both write grants high in one cycle");
  end

  grant_needs_req: assert property (
    @(posedge wr_clk) disable iff (wr_rst) (wr_grant & ~wr_valid) == '0
  ) else begin
    fail_count++;
    $error("write grant without a matching request");
  end

  // A held request that lost must win on the next cycle
  loser0_next: assert property (
    @(posedge wr_clk) disable iff (wr_rst) (wr_valid[0] && !wr_grant[0]) |=> wr_grant[0]
  ) else begin
    fail_count++;
    $error("client 0 request not granted on the cycle after losing");
  end

  loser1_next: assert property (
    @(posedge wr_clk) disable iff (wr_rst) (wr_valid[1] && !wr_grant[1]) |=> wr_grant[1]
  ) else begin
    fail_count++;
    $error("client 1 request not granted on the cycle after losing");
  end

  rd_latency: assert property (
    @(posedge wr_clk) disable iff (wr_rst) rd_addr_valid |=> rd_data_valid
  ) else begin
    fail_count++;
    $error("read data valid missing one cycle after the read address");
  end

  rd_no_extra: assert property (
    @(posedge wr_clk) disable iff (wr_rst) !rd_addr_valid |=> !rd_data_valid
  ) else begin
    fail_count++;
    $error("read data valid without a read address in the cycle before");
  end

endmodule

bind ram_subsys ram_subsys_properties props_i (
  .wr_clk        (wr_clk),
  .wr_rst        (wr_rst),
  .wr_valid      (wr_valid),
  .wr_grant      (wr_grant),
  .rd_addr_valid (rd_addr_valid),
  .rd_data_valid (rd_data_valid)
);

// File: dv/tb_ram_subsys.sv
// Testbench for the RAM subsystem with clock, reset, file-driven steps, grant model, checks, watchdog
`timescale 1ns/1ns

module tb_ram_subsys import ram_pkg::*; ();

  logic                                       wr_clk = 1'b0;
  logic                                       wr_rst;
  logic [num_writers-1:0]                     wr_valid;
  logic [num_writers-1:0][ram_addr_width-1:0] wr_addr;
  logic [num_writers-1:0][ram_width-1:0]      wr_data;
  logic [num_writers-1:0][ram_num_words-1:0]  wr_word_en;
  logic [num_writers-1:0]                     wr_grant;
  logic                                       rd_addr_valid;
  logic [ram_addr_width-1:0]                  rd_addr;
  logic                                       rd_data_valid;
  logic [ram_width-1:0]                       rd_data;

  // One line of the stimulus file
  typedef struct {
    string       name;
    logic [31:0] v0, a0, d0, be0, v1, a1, d1, be1, rv, ra, exp_rd;
  } step_t;

  step_t    steps [$];
  arb_pri_e model_pri   = pri_client0;
  int       n_lines     = 0;
  bit       stim_loaded = 1'b0;
  int       err_count   = 0;
  int       check_count = 0;
  int       test_count  = 0;
  int       test_fails  = 0;

  always #50 wr_clk = ~wr_clk;

  ram_subsys ram_subsys_i (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_word_en    (wr_word_en),
    .wr_grant      (wr_grant),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Fail %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  // Lone requester wins, a conflict goes to the priority holder and moves priority on
  task automatic predict_grant(input logic [num_writers-1:0] req,
                               output logic [num_writers-1:0] grant);
    if (&req) begin
      grant     = (model_pri == pri_client0) ? 2'b01 : 2'b10;
      model_pri = (model_pri == pri_client0) ? pri_client1 : pri_client0;
    end else begin
      grant = req;
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    int    lines;
    string line;
    step_t st;
    lines = 0;
    fd = $fopen("dv/ram_stimulus.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("Error: cannot open dv/ram_stimulus.txt for reading");
    end else begin
      while ($fgets(line, fd) != 0) begin
        lines++;
        // Skip blank lines and comment lines
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", st.name, st.v0, st.a0,
                      st.d0, st.be0, st.v1, st.a1, st.d1, st.be1, st.rv, st.ra, st.exp_rd);
          if (n == 12) begin
            steps.push_back(st);
          end else begin
            err_count++;
            $display("Error: stimulus line %0d could not be parsed", lines);
          end
        end
      end
      $fclose(fd);
      n_lines     = lines;
      stim_loaded = 1'b1;
    end
  endtask

  // Cycle 0 presents writes and read, losers hold, read data is checked in cycle 1
  task automatic run_step(input step_t st);
    logic [num_writers-1:0] pend;
    logic [num_writers-1:0] exp_grant;
    int                     cyc;
    bit                     more;
    pend = {st.v1[0], st.v0[0]};
    cyc  = 0;
    @(posedge wr_clk);
    wr_valid      <= pend;
    wr_addr[0]    <= st.a0[ram_addr_width-1:0];
    wr_addr[1]    <= st.a1[ram_addr_width-1:0];
    wr_data[0]    <= st.d0;
    wr_data[1]    <= st.d1;
    wr_word_en[0] <= st.be0[ram_num_words-1:0];
    wr_word_en[1] <= st.be1[ram_num_words-1:0];
    rd_addr_valid <= st.rv[0];
    rd_addr       <= st.ra[ram_addr_width-1:0];
    do begin
      @(negedge wr_clk);
      predict_grant(pend, exp_grant);
      check_value(st.name, "grant", exp_grant, wr_grant);
      // A request stays up until the DUT grants it
      pend = pend & ~wr_grant;
      check_value(st.name, "rd_data_valid", (cyc == 1) && st.rv[0], rd_data_valid);
      if (cyc == 1 && st.rv[0]) begin
        check_value(st.name, "rd_data", st.exp_rd, rd_data);
      end
      more = (pend != '0) || (st.rv[0] && cyc == 0);
      if (more) begin
        @(posedge wr_clk);
        wr_valid      <= pend;
        rd_addr_valid <= 1'b0;
        cyc++;
      end
    end while (more);
  endtask

  task automatic report_test(input string name, input int n_steps, input int errs);
    test_count++;
    if (errs == 0) begin
      $display("Test %s: passed, %0d steps", name, n_steps);
    end else begin
      test_fails++;
      $display("Test %s: failed, %0d steps, %0d errors", name, n_steps, errs);
    end
  endtask

  initial begin : main_seq
    string cur_test;
    int    test_steps;
    int    err_base;
    int    assert_fails;
    wr_rst        = 1'b1;
    wr_valid      = '0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_word_en    = '0;
    rd_addr_valid = 1'b0;
    rd_addr       = '0;
    cur_test      = "";
    test_steps    = 0;
    err_base      = 0;
    load_stimulus();
    repeat (8) @(posedge wr_clk);
    wr_rst <= 1'b0;
    foreach (steps[i]) begin
      if (steps[i].name != cur_test) begin
        if (test_steps > 0) begin
          report_test(cur_test, test_steps, err_count - err_base);
        end
        cur_test   = steps[i].name;
        test_steps = 0;
        err_base   = err_count;
      end
      run_step(steps[i]);
      test_steps++;
    end
    if (test_steps > 0) begin
      report_test(cur_test, test_steps, err_count - err_base);
    end
    @(posedge wr_clk);
    wr_valid      <= '0;
    rd_addr_valid <= 1'b0;
    repeat (2) @(posedge wr_clk);
    assert_fails = ram_subsys_i.props_i.fail_count;
    $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             test_count, test_count - test_fails, test_fails, check_count, err_count,
             assert_fails);
    if (err_count == 0 && assert_fails == 0 && test_count > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Each step needs at most two cycles, so four per file line leaves margin
  initial begin : watchdog
    int limit;
    wait (stim_loaded);
    limit = n_lines * 4 + 8;
    repeat (limit) @(posedge wr_clk);
    $display("Error: timeout, the stimulus did not finish within %0d cycles", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: dv/ram_stimulus.txt
# Columns: test v0 addr0 data0 be0 v1 addr1 data1 be1 rd_valid rd_addr rd_expected
# All numbers hex; v0/v1 request a write from client 0/1, be holds one bit per byte
# One step per line; a read sees writes granted in earlier steps only
# Reads before any write
reset_clear 0 0 00000000 0 0 0 00000000 0 1 0 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 3 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 5 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 7 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 8 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 a 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 c 00000000
reset_clear 0 0 00000000 0 0 0 00000000 0 1 f 00000000
# Full write then single bytes
full_byte 1 3 11223344 f 0 0 00000000 0 0 0 00000000
full_byte 1 3 000000aa 1 0 0 00000000 0 1 3 11223344
full_byte 0 0 00000000 0 1 3 0000bb00 2 1 3 112233aa
full_byte 1 3 cc000000 8 0 0 00000000 0 1 3 1122bbaa
full_byte 0 0 00000000 0 0 0 00000000 0 1 3 cc22bbaa
# Both clients at once to different addresses
arbitration 1 1 a0a0a0a0 f 1 2 b1b1b1b1 f 0 0 00000000
arbitration 1 4 c0c0c0c0 f 1 5 d1d1d1d1 f 0 0 00000000
arbitration 0 0 00000000 0 0 0 00000000 0 1 1 a0a0a0a0
arbitration 0 0 00000000 0 0 0 00000000 0 1 2 b1b1b1b1
arbitration 0 0 00000000 0 0 0 00000000 0 1 4 c0c0c0c0
arbitration 0 0 00000000 0 0 0 00000000 0 1 5 d1d1d1d1
# Conflicts on one address
same_addr 1 8 00000011 1 1 8 00002200 2 1 8 00000000
same_addr 0 0 00000000 0 0 0 00000000 0 1 8 00002211
same_addr 1 8 aaaaaaaa 3 1 8 bbbbbbbb 6 0 0 00000000
same_addr 0 0 00000000 0 0 0 00000000 0 1 8 00bbaaaa
same_addr 1 9 11111111 f 1 9 22222222 c 0 0 00000000
same_addr 0 0 00000000 0 0 0 00000000 0 1 9 22221111
# Read bypass around the write stage
bypass 1 c 12345678 f 0 0 00000000 0 1 c 00000000
bypass 0 0 00000000 0 1 c 9a000000 8 0 0 00000000
bypass 0 0 00000000 0 0 0 00000000 0 1 c 9a345678
bypass 1 c 0000bc00 2 0 0 00000000 0 0 0 00000000
bypass 0 0 00000000 0 0 0 00000000 0 1 c 9a34bc78
bypass 1 d ffffffff f 0 0 00000000 0 0 0 00000000
bypass 0 0 00000000 0 0 0 00000000 0 1 c 9a34bc78
bypass 0 0 00000000 0 0 0 00000000 0 1 d ffffffff
bypass 0 0 00000000 0 1 c 00000000 0 0 0 00000000
bypass 0 0 00000000 0 0 0 00000000 0 1 c 9a34bc78
bypass 1 c 55555555 f 0 0 00000000 0 1 c 9a34bc78
bypass 0 0 00000000 0 0 0 00000000 0 1 c 55555555

// File: tb.f
common/ram_pkg.sv
common/ram_wr_if.sv
logic/wr_arbiter.sv
ram/ram_flops.sv
ram/ram_subsys.sv
dv/ram_subsys_properties.sv
dv/tb_ram_subsys.sv

// File: Bender.yml
package:
  name: ram_subsys

sources:
  - common/ram_pkg.sv
  - common/ram_wr_if.sv
  - logic/wr_arbiter.sv
  - ram/ram_flops.sv
  - ram/ram_subsys.sv
  - target: simulation
    files:
      - dv/ram_subsys_properties.sv
      - dv/tb_ram_subsys.sv
